/* rtl/ppu_pkg.sv */
// ====================
// shared types, enums and constants of the
// N64 video front end: bus words, pixels,
// video info, config word and status word
// ====================

`default_nettype none

package ppu_pkg;

  // bus and pixel words
  typedef logic [6:0]  color7_t;
  typedef logic [7:0]  color8_t;
  typedef logic [20:0] rgb21_t;      // {R,G,B}, red on top
  typedef logic [23:0] rgb24_t;      // {R,G,B}, red on top
  typedef logic [3:0]  sync_word_t;  // {nVSYNC,nCLAMP,nHSYNC,nCSYNC}
  typedef logic [9:0]  line_cnt_t;
  typedef logic [2:0]  vinfo_t;      // {vdata_detected,palmode,n64_480i}
  typedef logic [7:0]  cfg_word_t;
  typedef logic [7:0]  ppu_state_t;

  typedef enum logic [2:0] {
    T480P, T720P, T960P, T1080P, T1200P, T1440P, T1440WP, TDIRECT
  } target_res_e;

  typedef enum logic [3:0] {
    USE_480P, USE_VGA, USE_720P, USE_960P, USE_1080P,
    USE_1200P, USE_1440P, USE_1440WP, USE_240P
  } vmode_e;

  // bit positions
  localparam int SYNC_NVSYNC_BIT = 3;
  localparam int SYNC_NHSYNC_BIT = 1;

  localparam int VINFO_VDATA_BIT = 2;
  localparam int VINFO_PAL_BIT   = 1;
  localparam int VINFO_480I_BIT  = 0;

  localparam int CFG_TRES_MSB      = 2;  // target resolution in [2:0]
  localparam int CFG_FORCE60_BIT   = 3;
  localparam int CFG_FORCE50_BIT   = 4;
  localparam int CFG_LLM_BIT       = 5;
  localparam int CFG_VGA480P_BIT   = 6;

  // timing of the bus
  localparam int DEMUX_PHASES          = 4;    // bus cycles per pixel
  localparam int VDATA_LOST_CYCLES     = 8;    // no sync for this long -> no video
  localparam int PAL_LINES_MIN_DEFAULT = 290;

endpackage

`default_nettype wire

/* rtl/n64_vinfo_detect.sv */
// ====================
// video info detector: video presence from
// regular sync words, PAL from the line count
// and interlacing from changing frame lengths
// ====================

`default_nettype none

module n64_vinfo_detect import ppu_pkg::*; #(
  parameter int unsigned pal_lines_min = PAL_LINES_MIN_DEFAULT
) (
  input  logic    N64_CLK_i,
  input  logic    rst_i,
  input  logic    nVDSYNC_i,
  input  color7_t VD_i,
  output vinfo_t  vinfo_o
);

  localparam int GAP_W = $clog2(VDATA_LOST_CYCLES) + 1;
  localparam logic [GAP_W-1:0] GAP_REGULAR = GAP_W'(DEMUX_PHASES - 1);
  localparam logic [GAP_W-1:0] GAP_LOST    = GAP_W'(VDATA_LOST_CYCLES - 1);

  logic             sync_cyc;
  sync_word_t       sync_cur;
  sync_word_t       sync_pre;
  logic [GAP_W-1:0] gap_cnt;       // non-sync cycles since last sync word
  logic [1:0]       run_cnt;
  logic             regular;
  logic             vstart;
  logic             hs_fall;
  line_cnt_t        line_cnt;
  line_cnt_t        frame_lines;
  line_cnt_t        frame_lines_pre;
  logic             frame_done;
  logic             vdata_detected;
  logic             palmode;
  logic             n64_480i;

  assign sync_cyc = ~nVDSYNC_i;
  assign sync_cur = VD_i[3:0];
  assign regular  = gap_cnt == GAP_REGULAR;
  assign vstart   = sync_cyc & ~sync_cur[SYNC_NVSYNC_BIT] & sync_pre[SYNC_NVSYNC_BIT];
  assign hs_fall  = sync_cyc & ~sync_cur[SYNC_NHSYNC_BIT] & sync_pre[SYNC_NHSYNC_BIT];

  // video presence
  // ====================
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      gap_cnt        <= '1;
      run_cnt        <= '0;
      vdata_detected <= 1'b0;
    end else if (sync_cyc) begin
      gap_cnt <= '0;
      if (regular) begin
        if (run_cnt == 2'd3)
          vdata_detected <= 1'b1;    // fourth regular sync word
        else
          run_cnt <= run_cnt + 2'd1;
      end else begin
        run_cnt <= 2'd1;             // new run starts here
      end
    end else begin
      if (gap_cnt != '1)
        gap_cnt <= gap_cnt + 1'b1;
      if (gap_cnt == GAP_LOST)
        vdata_detected <= 1'b0;
    end
  end

  // line and frame counting
  // ====================
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      sync_pre        <= '1;         // all syncs inactive
      line_cnt        <= '0;
      frame_lines     <= '0;
      frame_lines_pre <= '0;
      frame_done      <= 1'b0;
      palmode         <= 1'b0;
      n64_480i        <= 1'b0;
    end else begin
      frame_done <= vstart;
      if (sync_cyc)
        sync_pre <= sync_cur;
      if (vstart) begin
        frame_lines <= line_cnt;
        line_cnt    <= line_cnt_t'(hs_fall);  // line starting with vsync is the new frame's
      end else if (hs_fall && line_cnt != '1) begin
        line_cnt <= line_cnt + 1'b1;
      end
      // decide one edge after the vsync word
      if (frame_done) begin
        palmode         <= frame_lines > pal_lines_min;
        n64_480i        <= frame_lines != frame_lines_pre;
        frame_lines_pre <= frame_lines;
      end
    end
  end

  always_comb begin
    vinfo_o                  = '0;
    vinfo_o[VINFO_VDATA_BIT] = vdata_detected;
    vinfo_o[VINFO_PAL_BIT]   = palmode;
    vinfo_o[VINFO_480I_BIT]  = n64_480i;
  end

endmodule

`default_nettype wire

/* rtl/n64_vdemux.sv */
// ====================
// pixel demultiplexer: sync word plus
// R, G and B bus words -> one pixel
// ====================

`default_nettype none

module n64_vdemux import ppu_pkg::*; (
  input  logic       N64_CLK_i,
  input  logic       rst_i,
  input  logic       nVDSYNC_i,
  input  color7_t    VD_i,
  output logic       pix_valid_o,
  output rgb21_t     pix_rgb_o,
  output sync_word_t pix_sync_o
);

  localparam int PH_W = $clog2(DEMUX_PHASES);
  localparam logic [PH_W-1:0] PH_IDLE  = '0;
  localparam logic [PH_W-1:0] PH_RED   = PH_W'(1);
  localparam logic [PH_W-1:0] PH_GREEN = PH_W'(2);
  localparam logic [PH_W-1:0] PH_BLUE  = PH_W'(DEMUX_PHASES - 1);

  logic [PH_W-1:0] phase;      // idle or the colour expected next
  logic            blue_done;  // full pixel gathered
  sync_word_t      sync_q;
  color7_t         r_q;
  color7_t         g_q;
  color7_t         b_q;

  // phase control
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      phase       <= PH_IDLE;
      blue_done   <= 1'b0;
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= blue_done;
      blue_done   <= 1'b0;
      if (!nVDSYNC_i) begin
        phase <= PH_RED;                 // restart, drops an unfinished pixel
      end else if (phase != PH_IDLE) begin
        blue_done <= phase == PH_BLUE;
        phase     <= phase + 1'b1;       // wraps back to idle after blue
      end
    end
  end

  // word capture
  always_ff @(posedge N64_CLK_i) begin
    if (!nVDSYNC_i) begin
      sync_q <= VD_i[3:0];
    end else begin
      case (phase)
        PH_RED:   r_q <= VD_i;
        PH_GREEN: g_q <= VD_i;
        PH_BLUE:  b_q <= VD_i;
        default:  ;
      endcase
    end
  end

  // present pixel, next sync word may already be in
  always_ff @(posedge N64_CLK_i) begin
    if (blue_done) begin
      pix_rgb_o  <= {r_q, g_q, b_q};
      pix_sync_o <= sync_q;
    end
  end

endmodule

`default_nettype wire

/* rtl/ppu_output_stage.sv */
// ====================
// output stage: widened and blanked pixels
// with syncs and DE, config decode into
// video mode, 50 Hz, VCLK select and status
// ====================

`default_nettype none

module ppu_output_stage import ppu_pkg::*; (
  input  logic       N64_CLK_i,
  input  logic       rst_i,
  input  logic       pix_valid_i,
  input  rgb21_t     pix_rgb_i,
  input  sync_word_t pix_sync_i,
  input  vinfo_t     vinfo_i,
  input  cfg_word_t  ConfigSet_i,
  output rgb24_t     VD_o,
  output logic       HSYNC_o,
  output logic       VSYNC_o,
  output logic       DE_o,
  output logic       VCLK_sel_o,
  output vmode_e     vmode_o,
  output logic       vmode_50hz_o,
  output ppu_state_t PPUState_o
);

  // 7 -> 8 bit by repeating the MSB
  function automatic color8_t widen(color7_t c);
    return {c, c[6]};
  endfunction

  rgb24_t      pix_wide;
  target_res_e target;
  logic        use_vga;
  logic        llm;
  logic        hz50;
  logic        vclk_sel;
  vmode_e      vmode;

  assign pix_wide = {widen(pix_rgb_i[20:14]), widen(pix_rgb_i[13:7]), widen(pix_rgb_i[6:0])};

  // pixel output
  // ====================
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      VD_o    <= '0;
      HSYNC_o <= 1'b0;
      VSYNC_o <= 1'b0;
      DE_o    <= 1'b0;
    end else begin
      if (!vinfo_i[VINFO_VDATA_BIT])
        VD_o <= '0;                      // blank without video
      else if (pix_valid_i)
        VD_o <= pix_wide;
      if (pix_valid_i) begin
        HSYNC_o <= ~pix_sync_i[SYNC_NHSYNC_BIT];
        VSYNC_o <= ~pix_sync_i[SYNC_NVSYNC_BIT];
        DE_o    <= pix_sync_i[SYNC_NHSYNC_BIT] & pix_sync_i[SYNC_NVSYNC_BIT];
      end
    end
  end

  // config decode
  // ====================
  assign target  = target_res_e'(ConfigSet_i[CFG_TRES_MSB:0]);
  assign use_vga = ConfigSet_i[CFG_VGA480P_BIT];
  assign llm     = ConfigSet_i[CFG_LLM_BIT] | (target == TDIRECT);  // direct is always llm

  always_comb begin
    case (target)
      T720P:   vmode = USE_720P;
      T960P:   vmode = USE_960P;
      T1080P:  vmode = USE_1080P;
      T1200P:  vmode = USE_1200P;
      T1440P:  vmode = USE_1440P;
      T1440WP: vmode = USE_1440WP;
      TDIRECT: vmode = USE_240P;
      default: vmode = use_vga ? USE_VGA : USE_480P;
    endcase

    // no forced refresh rate under llm
    if (llm)
      hz50 = vinfo_i[VINFO_PAL_BIT];
    else if (ConfigSet_i[CFG_FORCE60_BIT])
      hz50 = 1'b0;
    else if (ConfigSet_i[CFG_FORCE50_BIT])
      hz50 = 1'b1;
    else
      hz50 = vinfo_i[VINFO_PAL_BIT];

    if (llm)
      vclk_sel = vinfo_i[VINFO_480I_BIT];
    else if (target == T720P || target == T1080P || target == T1440P)
      vclk_sel = 1'b0;
    else if (target == T480P)
      vclk_sel = ~use_vga;
    else
      vclk_sel = 1'b1;
  end

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      vmode_o      <= USE_480P;
      vmode_50hz_o <= 1'b0;
      VCLK_sel_o   <= 1'b0;
      PPUState_o   <= '0;
    end else begin
      vmode_o      <= vmode;
      vmode_50hz_o <= hz50;
      VCLK_sel_o   <= vclk_sel;
      PPUState_o   <= {target, hz50, llm, vinfo_i};  // vinfo fills bits 2:0
    end
  end

endmodule

`default_nettype wire

/* rtl/n64_ppu_top.sv */
// ====================
// N64 front end top: demux and video info
// detector on the bus, output stage behind
// ====================

`default_nettype none

module n64_ppu_top import ppu_pkg::*; #(
  parameter int unsigned pal_lines_min = PAL_LINES_MIN_DEFAULT
) (
  input  logic       N64_CLK_i,
  input  logic       rst_i,
  input  logic       nVDSYNC_i,
  input  color7_t    VD_i,
  input  cfg_word_t  ConfigSet_i,
  output rgb24_t     VD_o,
  output logic       HSYNC_o,
  output logic       VSYNC_o,
  output logic       DE_o,
  output logic       VCLK_sel_o,
  output vmode_e     vmode_o,
  output logic       vmode_50hz_o,
  output ppu_state_t PPUState_o
);

  logic       pix_valid;
  rgb21_t     pix_rgb;
  sync_word_t pix_sync;
  vinfo_t     vinfo;

  n64_vdemux vdemux_u (
    .N64_CLK_i   (N64_CLK_i),
    .rst_i       (rst_i),
    .nVDSYNC_i   (nVDSYNC_i),
    .VD_i        (VD_i),
    .pix_valid_o (pix_valid),
    .pix_rgb_o   (pix_rgb),
    .pix_sync_o  (pix_sync)
  );

  n64_vinfo_detect #(
    .pal_lines_min (pal_lines_min)
  ) vinfo_u (
    .N64_CLK_i (N64_CLK_i),
    .rst_i     (rst_i),
    .nVDSYNC_i (nVDSYNC_i),
    .VD_i      (VD_i),
    .vinfo_o   (vinfo)
  );

  ppu_output_stage out_u (
    .N64_CLK_i    (N64_CLK_i),
    .rst_i        (rst_i),
    .pix_valid_i  (pix_valid),
    .pix_rgb_i    (pix_rgb),
    .pix_sync_i   (pix_sync),
    .vinfo_i      (vinfo),
    .ConfigSet_i  (ConfigSet_i),
    .VD_o         (VD_o),
    .HSYNC_o      (HSYNC_o),
    .VSYNC_o      (VSYNC_o),
    .DE_o         (DE_o),
    .VCLK_sel_o   (VCLK_sel_o),
    .vmode_o      (vmode_o),
    .vmode_50hz_o (vmode_50hz_o),
    .PPUState_o   (PPUState_o)
  );

endmodule

`default_nettype wire

/* test/n64_ppu_props.sv */
// ====================
// concurrent assertions on the front end top
// ====================

`default_nettype none

module n64_ppu_props import ppu_pkg::*; (
  input wire logic       N64_CLK_i,
  input wire logic       rst_i,
  input wire logic       HSYNC_i,
  input wire logic       VSYNC_i,
  input wire logic       DE_i,
  input wire rgb24_t     VD_i,
  input wire vinfo_t     vinfo_i,
  input wire logic       VCLK_sel_i,
  input wire ppu_state_t PPUState_i
);
  timeunit 1ns;
  timeprecision 1ps;

  de_no_sync: assert property (@(posedge N64_CLK_i) disable iff (rst_i)
    DE_i |-> !HSYNC_i && !VSYNC_i)
    else $error("DE_o high during sync");

  blank_no_video: assert property (@(posedge N64_CLK_i) disable iff (rst_i)
    !vinfo_i[VINFO_VDATA_BIT] |=> VD_i == '0)
    else $error("VD_o not blanked without video");

  // bit 3 is low latency, bit 0 is n64_480i
  vclk_llm: assert property (@(posedge N64_CLK_i) disable iff (rst_i)
    PPUState_i[3] |-> VCLK_sel_i == PPUState_i[0])
    else $error("VCLK_sel_o differs from n64_480i under low latency");

endmodule

bind n64_ppu_top n64_ppu_props props_u (
  .N64_CLK_i  (N64_CLK_i),
  .rst_i      (rst_i),
  .HSYNC_i    (HSYNC_o),
  .VSYNC_i    (VSYNC_o),
  .DE_i       (DE_o),
  .VD_i       (VD_o),
  .vinfo_i    (vinfo),
  .VCLK_sel_i (VCLK_sel_o),
  .PPUState_i (PPUState_o)
);

`default_nettype wire

/* test/tb_n64_ppu.sv */
// ====================
// testbench for the N64 front end: bus stimulus,
// reference model, pixel compare, config sweep
// ====================

`default_nettype none

module tb_n64_ppu import ppu_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PAL_MIN      = 20;
  localparam int PIX_PER_LINE = 2;
  localparam int LINES_TOTAL  = 152 + 66;   // all frames of both runs
  localparam int BUS_CYCLES   = LINES_TOTAL * PIX_PER_LINE * DEMUX_PHASES + 3 * 12 + 8 * 4;
  localparam int WATCH_CYCLES = BUS_CYCLES + 2 * 128 * 3 + 500;

  logic       N64_CLK_i;
  logic       rst_i;
  logic       nVDSYNC_i;
  color7_t    VD_i;
  cfg_word_t  ConfigSet_i;
  rgb24_t     VD_o;
  logic       HSYNC_o;
  logic       VSYNC_o;
  logic       DE_o;
  logic       VCLK_sel_o;
  vmode_e     vmode_o;
  logic       vmode_50hz_o;
  ppu_state_t PPUState_o;

  integer     seed = 32'hbe26cbac;
  int         neg_cyc = 0;
  int         run_idx = 0;      // pixels since last bus gap
  int         due_q[$];
  rgb24_t     exp_pix_q[$];
  sync_word_t exp_sync_q[$];
  int         cur_lines = 0;    // model of the detector's line counter
  int         pre_lines = 0;
  vinfo_t     m_vi = '0;

  int frames_a[8] = '{22, 22, 22, 16, 16, 22, 16, 16};
  int frames_b[3] = '{22, 22, 22};

  n64_ppu_top #(.pal_lines_min(PAL_MIN)) uut (
    .N64_CLK_i(N64_CLK_i), .rst_i(rst_i), .nVDSYNC_i(nVDSYNC_i), .VD_i(VD_i),
    .ConfigSet_i(ConfigSet_i), .VD_o(VD_o), .HSYNC_o(HSYNC_o), .VSYNC_o(VSYNC_o),
    .DE_o(DE_o), .VCLK_sel_o(VCLK_sel_o), .vmode_o(vmode_o),
    .vmode_50hz_o(vmode_50hz_o), .PPUState_o(PPUState_o)
  );

  initial begin
    N64_CLK_i = 1'b0;
    forever #50 N64_CLK_i = ~N64_CLK_i;
  end

  initial begin
    #(WATCH_CYCLES * 100);
    $display("timeout, the test sequence did not complete in time");
    $display("Verification failed");
    $fatal(1);
  end

  // reference model
  // ====================
  function automatic rgb24_t widen_pixel(rgb21_t p, logic vdata);
    color7_t r;
    color7_t g;
    color7_t b;
    r = p[20:14];
    g = p[13:7];
    b = p[6:0];
    return vdata ? {r, r[6], g, g[6], b, b[6]} : 24'h0;
  endfunction

  // pal and interlace from the completed frame and the one before
  function automatic vinfo_t detect_vinfo(logic vdata, int done_lines, int prev_lines);
    return {vdata, done_lines > PAL_MIN, done_lines != prev_lines};
  endfunction

  // {vmode, 50 Hz, vclk select, status word}
  function automatic logic [13:0] decode_config(cfg_word_t c, vinfo_t vi);
    logic [2:0] t;
    logic       llm;
    logic       hz;
    logic       vclk;
    vmode_e     vm;
    t   = c[2:0];
    llm = c[5] | (t == 3'd7);
    case (t)
      3'd0:    vm = c[6] ? USE_VGA : USE_480P;
      3'd1:    vm = USE_720P;
      3'd2:    vm = USE_960P;
      3'd3:    vm = USE_1080P;
      3'd4:    vm = USE_1200P;
      3'd5:    vm = USE_1440P;
      3'd6:    vm = USE_1440WP;
      default: vm = USE_240P;
    endcase
    if (llm || (!c[3] && !c[4]))
      hz = vi[1];
    else
      hz = !c[3];                            // force60 wins over force50
    if (llm)
      vclk = vi[0];
    else if (t == 3'd1 || t == 3'd3 || t == 3'd5)
      vclk = 1'b0;
    else if (t == 3'd0)
      vclk = !c[6];
    else
      vclk = 1'b1;
    return {vm, hz, vclk, t, hz, llm, vi};
  endfunction

  // compare tasks
  // ====================
  task automatic stop_on_error();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic rgb_compare(string name, rgb24_t e, rgb24_t a);
    if (e !== a) begin
      $display("FAIL %s expected %h actual %h", name, e, a);
      stop_on_error();
    end
  endtask

  task automatic vinfo_compare(vinfo_t e, vinfo_t a);
    if (e !== a) begin
      $display("FAIL vinfo in PPUState_o expected %h actual %h", e, a);
      stop_on_error();
    end
  endtask

  task automatic vmode_compare(vmode_e e, vmode_e a, logic e50, logic a50);
    if (e !== a || e50 !== a50) begin
      $display("FAIL vmode_o/vmode_50hz_o expected %h/%h actual %h/%h", e, e50, a, a50);
      stop_on_error();
    end
  endtask

  task automatic state_compare(string name, ppu_state_t e, ppu_state_t a);
    if (e !== a) begin
      $display("FAIL %s expected %h actual %h", name, e, a);
      stop_on_error();
    end
  endtask

  task automatic level_compare(string name, logic e, logic a);
    if (e !== a) begin
      $display("FAIL %s expected %h actual %h", name, e, a);
      stop_on_error();
    end
  endtask

  // pixel compare, two edges after each checked B sample
  always @(negedge N64_CLK_i) begin
    neg_cyc <= neg_cyc + 1;
    if (due_q.size() > 0 && due_q[0] == neg_cyc) begin
      rgb_compare("VD_o", exp_pix_q[0], VD_o);
      level_compare("HSYNC_o", ~exp_sync_q[0][1], HSYNC_o);
      level_compare("VSYNC_o", ~exp_sync_q[0][3], VSYNC_o);
      level_compare("DE_o", exp_sync_q[0][1] & exp_sync_q[0][3], DE_o);
      void'(due_q.pop_front());
      void'(exp_pix_q.pop_front());
      void'(exp_sync_q.pop_front());
    end
  end

  // bus stimulus
  // ====================
  task automatic send_pixel(sync_word_t s);
    rgb21_t p;
    p = 21'($random(seed));
    @(posedge N64_CLK_i);
    nVDSYNC_i <= 1'b0;
    VD_i      <= {3'b000, s};
    for (int i = 2; i >= 0; i--) begin
      @(posedge N64_CLK_i);
      nVDSYNC_i <= 1'b1;
      VD_i      <= p[i*7 +: 7];
    end
    if (run_idx >= 3) begin                  // video is surely detected by now
      due_q.push_back(neg_cyc + 3);
      exp_pix_q.push_back(widen_pixel(p, 1'b1));
      exp_sync_q.push_back(s);
    end
    run_idx++;
  endtask

  task automatic bus_idle(int n);
    repeat (n) begin
      @(posedge N64_CLK_i);
      nVDSYNC_i <= 1'b1;
      VD_i      <= '0;
    end
    run_idx = 0;
  endtask

  task automatic drive_frame(int lines);
    m_vi      = detect_vinfo(1'b1, cur_lines, pre_lines);  // decision on the completed frame
    pre_lines = cur_lines;
    for (int l = 0; l < lines; l++)
      for (int p = 0; p < PIX_PER_LINE; p++)
        send_pixel({(l != 0), 1'b1, (p != 0), 1'b1});
    cur_lines = lines;
    @(negedge N64_CLK_i);
    vinfo_compare(m_vi, PPUState_o[2:0]);
  endtask

  task automatic sweep_config();
    logic [13:0] e;
    for (int c = 0; c < 128; c++) begin
      @(posedge N64_CLK_i);
      ConfigSet_i <= cfg_word_t'(c);
      @(posedge N64_CLK_i);
      @(posedge N64_CLK_i);
      @(negedge N64_CLK_i);
      e = decode_config(cfg_word_t'(c), {1'b0, m_vi[1:0]});
      vmode_compare(vmode_e'(e[13:10]), vmode_o, e[9], vmode_50hz_o);
      level_compare("VCLK_sel_o", e[8], VCLK_sel_o);
      state_compare("PPUState_o", e[7:0], PPUState_o);
    end
  endtask

  // main sequence
  // ====================
  initial begin
    rst_i       = 1'b1;
    nVDSYNC_i   = 1'b1;
    VD_i        = '0;
    ConfigSet_i = '0;
    repeat (3) @(posedge N64_CLK_i);
    rst_i <= 1'b0;

    // presence detection and loss
    @(negedge N64_CLK_i);
    rgb_compare("VD_o", 24'h0, VD_o);
    vinfo_compare(3'b000, PPUState_o[2:0]);
    repeat (3) send_pixel(4'b1111);
    @(negedge N64_CLK_i);
    vinfo_compare(3'b000, PPUState_o[2:0]);
    send_pixel(4'b1111);
    @(negedge N64_CLK_i);
    vinfo_compare(3'b100, PPUState_o[2:0]);
    bus_idle(12);
    @(negedge N64_CLK_i);
    vinfo_compare(3'b000, PPUState_o[2:0]);
    rgb_compare("VD_o", 24'h0, VD_o);

    // pixels, PAL and interlace detection
    foreach (frames_a[i]) drive_frame(frames_a[i]);
    bus_idle(12);
    sweep_config();                          // palmode 0 here
    foreach (frames_b[i]) drive_frame(frames_b[i]);
    bus_idle(12);
    sweep_config();                          // palmode 1 here

    if (due_q.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("%0d pixel compares were never reached", due_q.size());
      $display("Verification failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* list.f */
rtl/ppu_pkg.sv
rtl/n64_vinfo_detect.sv
rtl/n64_vdemux.sv
rtl/ppu_output_stage.sv
rtl/n64_ppu_top.sv
test/n64_ppu_props.sv
test/tb_n64_ppu.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_n64_ppu
FILELIST  = list.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
